//--- src/core_cfg_pkg.sv
package core_cfg_pkg;

  // datapath and pc width
  localparam int xlen = 64;

  // architectural register file
  localparam int reg_count = 32;
  localparam int reg_idx_w = 5;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;

  // instruction memory, one 32-bit word per entry
  localparam int imem_depth  = 256;
  localparam int imem_addr_w = 8;

  // memory covers reset_pc .. reset_pc + imem_depth*4 - 1
  // pc word index is pc[9:2] relative to reset_pc

endpackage

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

  // base opcodes, inst[6:0]
  localparam logic [6:0] op_addi   = 7'b0010011;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 of addi within the op-imm group
  localparam logic [2:0] funct3_addi = 3'b000;

  // only the exact word counts as ebreak
  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

  // decoded instruction
  typedef struct packed {
    // destination and source register index
    logic [core_cfg_pkg::reg_idx_w-1:0] rd;
    logic [core_cfg_pkg::reg_idx_w-1:0] rs1;
    // immediate, already sign-extended
    logic [core_cfg_pkg::xlen-1:0]      imm;
    // operand a from pc instead of rs1
    logic                               use_pc_a;
    // jump, link into rd
    logic                               is_jal;
    // stop request
    logic                               is_ebreak;
    // unsupported encoding, acts as nop
    logic                               illegal;
    // instruction writes rd
    logic                               wb_en;
  } dec_t;

  // write-back request into the register file
  typedef struct packed {
    logic                               en;
    logic [core_cfg_pkg::reg_idx_w-1:0] rd;
    logic [core_cfg_pkg::xlen-1:0]      data;
  } wb_t;

  // rd == 0 with en set is legal
  // the register file drops that write

endpackage

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                                clk,
  input  logic                                arst_n,
  // program load port
  input  logic                                prog_we,
  input  logic [core_cfg_pkg::imem_addr_w-1:0] prog_addr,
  input  logic [31:0]                         prog_data,
  // from execute
  input  logic [core_cfg_pkg::xlen-1:0]       next_pc,
  input  logic                                halt_req,
  // to decode / execute / status
  output logic [core_cfg_pkg::xlen-1:0]       pc,
  output logic [31:0]                         inst,
  output logic                                halted
);

  // instruction words, loaded only through the program port
  logic [31:0] imem [core_cfg_pkg::imem_depth];

  // byte offset of pc inside the memory window
  logic [core_cfg_pkg::xlen-1:0]        pc_off;
  logic [core_cfg_pkg::imem_addr_w-1:0] word_idx;
  logic                                 in_range;

  // program load, works in and out of reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // below reset_pc wraps to a huge offset, so it falls out of range too
  assign pc_off   = pc - core_cfg_pkg::reset_pc;
  assign word_idx = pc_off[core_cfg_pkg::imem_addr_w+1:2];
  assign in_range = (pc_off[core_cfg_pkg::xlen-1:2] < core_cfg_pkg::imem_depth);

  // out of range reads zero, decoded as illegal
  assign inst = in_range ? imem[word_idx] : 32'h0;

  // pc register and halt latch
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= core_cfg_pkg::reset_pc;
      halted <= 1'b0;
    end else begin
      // sticky until reset
      if (halt_req) begin
        halted <= 1'b1;
      end
      // frozen once halted
      if (!halted) begin
        pc <= next_pc;
      end
    end
  end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]       inst,
  output rv_isa_pkg::dec_t  dec
);

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;

  // immediates per format, sign-extended to xlen
  logic [core_cfg_pkg::xlen-1:0] imm_i;
  logic [core_cfg_pkg::xlen-1:0] imm_u;
  logic [core_cfg_pkg::xlen-1:0] imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // i-type: inst[31:20]
  assign imm_i = {{(core_cfg_pkg::xlen-12){inst[31]}}, inst[31:20]};

  // u-type: upper 20 bits, low 12 zero
  assign imm_u = {{(core_cfg_pkg::xlen-32){inst[31]}}, inst[31:12], 12'h000};

  // j-type: scrambled 20-bit offset, bit 0 always zero
  assign imm_j = {{(core_cfg_pkg::xlen-21){inst[31]}},
                  inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults give a nop with illegal raised
    dec           = '0;
    dec.rd        = inst[11:7];
    dec.rs1       = inst[19:15];
    dec.illegal   = 1'b1;

    case (opcode)
      rv_isa_pkg::op_addi: begin
        // only funct3 000 of the op-imm group
        if (funct3 == rv_isa_pkg::funct3_addi) begin
          dec.imm     = imm_i;
          dec.wb_en   = 1'b1;
          dec.illegal = 1'b0;
        end
      end

      rv_isa_pkg::op_auipc: begin
        dec.imm      = imm_u;
        dec.use_pc_a = 1'b1;
        dec.wb_en    = 1'b1;
        dec.illegal  = 1'b0;
      end

      rv_isa_pkg::op_jal: begin
        // pc operand too, adder forms the jump target
        dec.imm      = imm_j;
        dec.use_pc_a = 1'b1;
        dec.is_jal   = 1'b1;
        dec.wb_en    = 1'b1;
        dec.illegal  = 1'b0;
      end

      rv_isa_pkg::op_system: begin
        // ecall, csr ops etc stay illegal
        if (inst == rv_isa_pkg::ebreak_inst) begin
          dec.is_ebreak = 1'b1;
          dec.illegal   = 1'b0;
        end
      end

      default: begin
        // unsupported opcode, defaults hold
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                                clk,
  input  logic                                arst_n,
  // write-back from execute
  input  rv_isa_pkg::wb_t                     wb,
  // operand read
  input  logic [core_cfg_pkg::reg_idx_w-1:0]  rs1_idx,
  output logic [core_cfg_pkg::xlen-1:0]       rs1_data,
  // debug read, top-level visibility
  input  logic [core_cfg_pkg::reg_idx_w-1:0]  dbg_raddr,
  output logic [core_cfg_pkg::xlen-1:0]       dbg_rdata
);

  // x0 entry exists but is never written
  logic [core_cfg_pkg::xlen-1:0] regs [core_cfg_pkg::reg_count];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // whole array clears on reset
      for (int i = 0; i < core_cfg_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // combinational reads, x0 hardwired to zero
  assign rs1_data  = (rs1_idx == '0) ? '0 : regs[rs1_idx];

  // write shows up here the cycle after the edge
  assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

//--- src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  rv_isa_pkg::dec_t                dec,
  input  logic [core_cfg_pkg::xlen-1:0]   pc,
  input  logic [core_cfg_pkg::xlen-1:0]   rs1_data,
  input  logic                            halted,
  output rv_isa_pkg::wb_t                 wb,
  output logic [core_cfg_pkg::xlen-1:0]   next_pc,
  output logic                            halt_req
);

  // adder operands and outputs
  logic [core_cfg_pkg::xlen-1:0] op_a;
  logic [core_cfg_pkg::xlen-1:0] sum;
  logic [core_cfg_pkg::xlen-1:0] pc_plus4;

  // pc for auipc / jal, rs1 for addi
  assign op_a = dec.use_pc_a ? pc : rs1_data;

  // one adder, operand b is always the immediate
  // addi result, auipc result, or jal target
  assign sum = op_a + dec.imm;

  // sequential pc, also the jal link value
  assign pc_plus4 = pc + core_cfg_pkg::xlen'(4);

  // write-back request
  always_comb begin
    // no writes at all once halted
    wb.en   = dec.wb_en & ~halted;
    wb.rd   = dec.rd;
    wb.data = dec.is_jal ? pc_plus4 : sum;
  end

  // illegal and ebreak fall through to pc+4
  assign next_pc = dec.is_jal ? sum : pc_plus4;

  // latched in fetch on the next edge
  assign halt_req = dec.is_ebreak;

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input  logic                                 clk,
  input  logic                                 arst_n,
  // program load
  input  logic                                 prog_we,
  input  logic [core_cfg_pkg::imem_addr_w-1:0] prog_addr,
  input  logic [31:0]                          prog_data,
  // debug register read
  input  logic [core_cfg_pkg::reg_idx_w-1:0]   dbg_raddr,
  output logic [core_cfg_pkg::xlen-1:0]        dbg_rdata,
  // status
  output logic [core_cfg_pkg::xlen-1:0]        pc,
  output logic                                 halted,
  output logic                                 illegal
);

  // fetch -> decode
  logic [31:0]                   inst;
  // decode -> execute
  rv_isa_pkg::dec_t              dec;
  // register file -> execute
  logic [core_cfg_pkg::xlen-1:0] rs1_data;
  // execute -> register file / fetch
  rv_isa_pkg::wb_t               wb;
  logic [core_cfg_pkg::xlen-1:0] next_pc;
  logic                          halt_req;

  fetch_unit i_fetch_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .next_pc   (next_pc),
    .halt_req  (halt_req),
    .pc        (pc),
    .inst      (inst),
    .halted    (halted)
  );

  inst_decoder i_inst_decoder (
    .inst (inst),
    .dec  (dec)
  );

  // rs1 index straight out of the decoded struct
  reg_file i_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb        (wb),
    .rs1_idx   (dec.rs1),
    .rs1_data  (rs1_data),
    .dbg_raddr (dbg_raddr),
    .dbg_rdata (dbg_rdata)
  );

  exec_unit i_exec_unit (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .halted   (halted),
    .wb       (wb),
    .next_pc  (next_pc),
    .halt_req (halt_req)
  );

  // level, follows the word currently at pc
  assign illegal = dec.illegal;

endmodule

//--- verif/rv_core_asserts.sv
`timescale 1ns/1ps

module rv_core_asserts (
  input logic                          clk,
  input logic                          arst_n,
  input logic [core_cfg_pkg::xlen-1:0] pc,
  input logic                          halted
);

  // failed assertions so far
  int fail_count = 0;

  // frozen core keeps its pc
  pc_frozen: assert property (@(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
    else begin
      fail_count++;
      $error("pc changed while halted");
    end

  // only word fetches
  pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("pc not 4-byte aligned");
    end

  // halt is sticky, only reset clears it
  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
      fail_count++;
      $error("halted dropped without reset");
    end

endmodule

bind rv_core_top rv_core_asserts i_rv_core_asserts (
  .clk(clk), .arst_n(arst_n), .pc(pc), .halted(halted)
);

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int n_tests = 6;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  localparam logic [63:0] base = core_cfg_pkg::reset_pc;

  logic        clk;
  logic        arst_n;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;
  logic [4:0]  dbg_raddr;
  logic [63:0] dbg_rdata;
  logic [63:0] pc;
  logic        halted;
  logic        illegal;

  // program image, word i lands at reset_pc + 4*i
  logic [31:0] prog [$];
  logic [31:0] lfsr = 32'ha82db48e;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;

  rv_core_top i_rv_core_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 200 cycles of 4 ns per test
  initial begin
    #(n_tests * 200 * 4);
    $display("timeout: tests did not complete within %0d ns", n_tests * 200 * 4);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // galois lfsr x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [4:0] r;
    r = 5'(rand_bits(5));
    return (r == 5'd0) ? 5'd1 : r;
  endfunction

  // encoders straight from the base isa formats
  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1,
                                           logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_auipc(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
  endfunction

  task automatic check_eq(string name, logic [63:0] got, logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  // debug port is combinational, short settle before sampling
  task automatic check_reg(logic [4:0] idx, logic [63:0] expected);
    dbg_raddr = idx;
    #0.2;
    check_eq($sformatf("x%0d", idx), dbg_rdata, expected);
  endtask

  // one instruction retires per edge
  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  // reset held low for at least 3 cycles, image written meanwhile
  task automatic load_and_reset();
    int low_cycles;
    step();
    arst_n = 1'b0;
    low_cycles = 0;
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = 8'(i);
      prog_data = prog[i];
      step();
      low_cycles++;
    end
    prog_we = 1'b0;
    while (low_cycles < 3) begin
      step();
      low_cycles++;
    end
    arst_n = 1'b1;
  endtask

  task automatic report_test(string name, int err0);
    tests_run++;
    $display("test %s finished, %0d mismatches", name, errors - err0);
  endtask

  task automatic test_reset_flow();
    int err0;
    err0 = errors;
    prog.delete();
    // four nops then stop
    repeat (4) prog.push_back(enc_addi(5'd0, 5'd0, 12'd0));
    prog.push_back(ebreak_word);
    load_and_reset();
    for (int k = 0; k <= 4; k++) begin
      check_eq("pc", pc, base + 64'(4 * k));
      check_eq("halted", halted, 1'b0);
      check_eq("illegal", illegal, 1'b0);
      if (k < 4) step();
    end
    report_test("reset_flow", err0);
  endtask

  task automatic test_addi_chain();
    int err0;
    logic [4:0]  rd_q [8];
    logic [63:0] sum_q [8];
    logic [4:0]  prev;
    logic [11:0] imm;
    logic [63:0] sum;
    err0 = errors;
    prog.delete();
    prev = 5'd0;
    sum  = '0;
    // each addi adds onto the previous destination
    for (int k = 0; k < 8; k++) begin
      imm      = 12'(rand_bits(12));
      rd_q[k]  = rand_reg();
      sum      = sum + {{52{imm[11]}}, imm};
      sum_q[k] = sum;
      prog.push_back(enc_addi(rd_q[k], prev, imm));
      prev = rd_q[k];
    end
    // x0 destination, result dropped
    prog.push_back(enc_addi(5'd0, prev, 12'(rand_bits(12))));
    prog.push_back(ebreak_word);
    load_and_reset();
    for (int k = 0; k < 8; k++) begin
      step();
      check_reg(rd_q[k], sum_q[k]);
    end
    step();
    check_reg(5'd0, 64'd0);
    check_reg(prev, sum);
    report_test("addi_chain", err0);
  endtask

  task automatic test_auipc();
    int err0;
    logic [4:0]  rd_q [3];
    logic [63:0] exp_q [3];
    logic [19:0] imm;
    err0 = errors;
    prog.delete();
    for (int k = 0; k < 3; k++) begin
      imm      = 20'(rand_bits(20));
      rd_q[k]  = rand_reg();
      exp_q[k] = base + 64'(4 * k) + {{32{imm[19]}}, imm, 12'h000};
      prog.push_back(enc_auipc(rd_q[k], imm));
    end
    prog.push_back(ebreak_word);
    load_and_reset();
    for (int k = 0; k < 3; k++) begin
      step();
      check_reg(rd_q[k], exp_q[k]);
    end
    report_test("auipc", err0);
  endtask

  task automatic test_jal();
    int err0;
    // word 0 -> 4 -> 1 -> 6, forward and backward
    int at_q [3] = '{0, 4, 1};
    int off_q [3] = '{16, -12, 20};
    logic [63:0] jaddr;
    err0 = errors;
    prog.delete();
    repeat (7) prog.push_back(ebreak_word);
    for (int k = 0; k < 3; k++) begin
      prog[at_q[k]] = enc_jal(5'(k + 1), off_q[k]);
    end
    load_and_reset();
    for (int k = 0; k < 3; k++) begin
      jaddr = base + 64'(4 * at_q[k]);
      step();
      check_eq("pc", pc, jaddr + 64'(off_q[k]));
      check_reg(5'(k + 1), jaddr + 64'd4);
    end
    report_test("jal", err0);
  endtask

  task automatic test_ebreak();
    int err0;
    err0 = errors;
    prog.delete();
    prog.push_back(enc_addi(5'd5, 5'd0, 12'd123));
    // -7
    prog.push_back(enc_addi(5'd6, 5'd0, 12'hff9));
    prog.push_back(ebreak_word);
    prog.push_back(enc_addi(5'd5, 5'd0, 12'd1));
    load_and_reset();
    step();
    step();
    check_eq("halted", halted, 1'b0);
    step();
    check_eq("halted", halted, 1'b1);
    // the ebreak edge still moves pc on by 4, then it freezes
    repeat (20) begin
      step();
      check_eq("pc", pc, base + 64'd12);
    end
    check_reg(5'd5, 64'd123);
    check_reg(5'd6, 64'(-7));
    report_test("ebreak", err0);
  endtask

  task automatic test_illegal();
    int err0;
    err0 = errors;
    prog.delete();
    prog.push_back(enc_addi(5'd7, 5'd0, 12'd55));
    // xori x7, x0, 0 and ecall, both outside the set
    prog.push_back(32'h0000_4393);
    prog.push_back(32'h0000_0073);
    prog.push_back(ebreak_word);
    load_and_reset();
    for (int k = 1; k <= 3; k++) begin
      step();
      check_eq("pc", pc, base + 64'(4 * k));
      check_eq("illegal", illegal, (k < 3) ? 1'b1 : 1'b0);
      check_reg(5'd7, 64'd55);
    end
    report_test("illegal", err0);
  endtask

  initial begin
    arst_n    = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_raddr = '0;
    test_reset_flow();
    test_addi_chain();
    test_auipc();
    test_jal();
    test_ebreak();
    test_illegal();
    // bound assertion failures count as errors too
    errors += i_rv_core_top.i_rv_core_asserts.fail_count;
    $display("done: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
src/core_cfg_pkg.sv
src/rv_isa_pkg.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/rv_core_top.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - src/core_cfg_pkg.sv
  - src/rv_isa_pkg.sv
  - src/fetch_unit.sv
  - src/inst_decoder.sv
  - src/reg_file.sv
  - src/exec_unit.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_asserts.sv
      - verif/rv_core_tb.sv
